//--- src/hvc_kbd_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HVC keyboard package: USB report and $4016 command types, modifier bits
// and the HID key map of the Family BASIC keyboard matrix
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package hvc_kbd_pkg;

    // One HID usage code
    typedef logic [7:0] usb_keycode_t;

    // Boot protocol report without the reserved byte
    typedef struct packed {
        logic [7:0]             modifiers;
        usb_keycode_t [5:0]     keys;
    } usb_report_t;

    // Byte written to $4016
    typedef struct packed {
        logic [4:0] unused;
        logic       enable;
        logic       column;
        logic       scan_reset;
    } hvc_cmd_t;

    // Row 9 sits past the last matrix row
    typedef logic [3:0] hvc_row_t;

    // Key bits of one row and column, bit 0 maps to $4017 bit 1
    typedef logic [3:0] hvc_nibble_t;

    localparam int HVC_ROWS = 9;

    // Positions in the modifier byte
    localparam int MOD_LCTRL  = 0;
    localparam int MOD_LSHIFT = 1;
    localparam int MOD_RCTRL  = 4;
    localparam int MOD_RSHIFT = 5;

    localparam usb_keycode_t KEY_NONE = 8'h00;

    // Indexed as [row][column][bit]
    // Ctrl and Shift positions come from the modifier byte instead
    localparam usb_keycode_t HVC_KEYMAP [HVC_ROWS][2][4] = '{
        '{
            // F8 RETURN [ ]
            '{8'h41, 8'h28, 8'h2F, 8'h30},
            // STOP, yen, KANA unmapped; right Shift at bit 2
            '{KEY_NONE, KEY_NONE, KEY_NONE, KEY_NONE}
        },
        '{
            // F7 @ (on key 2) then ; with : left unmapped
            '{8'h40, 8'h1F, KEY_NONE, 8'h33},
            // - and / only
            '{KEY_NONE, 8'h2D, 8'h38, KEY_NONE}
        },
        '{
            // F6 O L K
            '{8'h3F, 8'h12, 8'h0F, 8'h0E},
            // 0 P comma and keypad dot
            '{8'h27, 8'h13, 8'h36, 8'h63}
        },
        '{
            // F5 I U J
            '{8'h3E, 8'h0C, 8'h18, 8'h0D},
            // 8 9 N M
            '{8'h25, 8'h26, 8'h11, 8'h10}
        },
        '{
            // F4 Y G H
            '{8'h3D, 8'h1C, 8'h0A, 8'h0B},
            // 6 7 V B
            '{8'h23, 8'h24, 8'h19, 8'h05}
        },
        '{
            // F3 T R D
            '{8'h3C, 8'h17, 8'h15, 8'h07},
            // 4 5 C F
            '{8'h21, 8'h22, 8'h06, 8'h09}
        },
        '{
            // F2 W S A
            '{8'h3B, 8'h1A, 8'h16, 8'h04},
            // 3 E Z X
            '{8'h20, 8'h08, 8'h1D, 8'h1B}
        },
        '{
            // F1 ESC Q and Ctrl
            '{8'h3A, 8'h29, 8'h14, KEY_NONE},
            // 2 1 GRPH (SysRq) and left Shift
            '{8'h1F, 8'h1E, 8'h46, KEY_NONE}
        },
        '{
            // Cursor right left up, CLR HOME unmapped
            '{8'h4F, 8'h50, 8'h52, KEY_NONE},
            // INS DEL (Backspace) SPACE and cursor down
            '{8'h49, 8'h2A, 8'h2C, 8'h51}
        }
    };

endpackage

`default_nettype wire

//--- src/hvc_key_matrix.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HVC key matrix: finds which keys of one row and column are held in a
// USB boot report
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module hvc_key_matrix (
    input  hvc_kbd_pkg::usb_report_t    i_report,
    input  hvc_kbd_pkg::hvc_row_t       i_row,
    input  logic                        i_column,
    output hvc_kbd_pkg::hvc_nibble_t    o_pressed
);

    import hvc_kbd_pkg::*;

    localparam int KEY_SLOTS = 6;

    // Matrix positions that follow the modifier byte
    localparam hvc_row_t ROW_CTRL   = 4'd7;
    localparam hvc_row_t ROW_LSHIFT = 4'd7;
    localparam hvc_row_t ROW_RSHIFT = 4'd0;
    localparam int BIT_CTRL   = 3;
    localparam int BIT_LSHIFT = 3;
    localparam int BIT_RSHIFT = 2;

    // True when any report slot carries a mapped code
    function automatic logic key_held(usb_report_t report, usb_keycode_t code);
        logic hit;
        hit = 1'b0;
        for (int s = 0; s < KEY_SLOTS; s++) begin
            if (report.keys[s] == code) begin
                hit = 1'b1;
            end
        end
        return hit && (code != KEY_NONE);
    endfunction

    logic        row_valid;
    hvc_row_t    row_sel;
    logic        ctrl_held;
    logic        lshift_held;
    logic        rshift_held;
    hvc_nibble_t map_hits;

    assign row_valid = (i_row < hvc_row_t'(HVC_ROWS));

    // Keep the table lookup in range past the last row
    assign row_sel = row_valid ? i_row : '0;

    // Either Ctrl key drives the single HVC Ctrl
    assign ctrl_held   = i_report.modifiers[MOD_LCTRL] | i_report.modifiers[MOD_RCTRL];
    assign lshift_held = i_report.modifiers[MOD_LSHIFT];
    assign rshift_held = i_report.modifiers[MOD_RSHIFT];

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            map_hits[b] = key_held(i_report, HVC_KEYMAP[row_sel][i_column][b]);
        end

        if (row_sel == ROW_CTRL && !i_column) begin
            map_hits[BIT_CTRL] = ctrl_held;
        end
        if (row_sel == ROW_LSHIFT && i_column) begin
            map_hits[BIT_LSHIFT] = lshift_held;
        end
        if (row_sel == ROW_RSHIFT && i_column) begin
            map_hits[BIT_RSHIFT] = rshift_held;
        end
    end

    // Nothing is pressed once the scan has run off the matrix
    assign o_pressed = row_valid ? map_hits : '0;

endmodule

`default_nettype wire

//--- src/hvc_scan_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HVC scan control: row and column walk on $4016 writes, $4017 data byte
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module hvc_scan_ctrl (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_wr_4016,
    input  hvc_kbd_pkg::hvc_cmd_t       i_data_4016,
    input  hvc_kbd_pkg::hvc_nibble_t    i_pressed,
    output hvc_kbd_pkg::hvc_row_t       o_row,
    output logic                        o_column,
    output logic [7:0]                  o_data_4017
);

    import hvc_kbd_pkg::*;

    // Row value once all matrix rows are read
    localparam hvc_row_t ROW_PAST = hvc_row_t'(HVC_ROWS);

    logic        enable_q;
    logic        column_q;
    hvc_row_t    row_q;
    logic        row_step;
    hvc_nibble_t nibble;

    // Column 1 -> 0 moves to the next row
    assign row_step = column_q && !i_data_4016.column;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            enable_q <= 1'b0;
            column_q <= 1'b0;
            row_q    <= '0;
        end else if (i_wr_4016) begin
            enable_q <= i_data_4016.enable;
            if (i_data_4016.enable) begin
                if (i_data_4016.scan_reset) begin
                    column_q <= 1'b0;
                    row_q    <= '0;
                end else begin
                    column_q <= i_data_4016.column;
                    // Stops at the row past the matrix
                    if (row_step && row_q != ROW_PAST) begin
                        row_q <= row_q + 4'd1;
                    end
                end
            end
        end
    end

    // Keys read active low, idle reads all ones
    always_comb begin
        nibble = 4'hF;
        if (enable_q && row_q < ROW_PAST) begin
            nibble = ~i_pressed;
        end
    end

    assign o_data_4017 = {3'b000, nibble, 1'b0};
    assign o_row       = row_q;
    assign o_column    = column_q;

endmodule

`default_nettype wire

//--- src/hvc_keyboard.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HVC-007 keyboard top: USB keyboard report seen as a Family BASIC keyboard
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module hvc_keyboard (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_wr_4016,
    input  hvc_kbd_pkg::hvc_cmd_t       i_data_4016,
    input  hvc_kbd_pkg::usb_report_t    i_report,
    output logic [7:0]                  o_data_4017
);

    import hvc_kbd_pkg::*;

    // Scan position out, pressed keys back
    hvc_row_t    scan_row;
    logic        scan_column;
    hvc_nibble_t matrix_pressed;

    hvc_scan_ctrl u_scan (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_wr_4016   (i_wr_4016),
        .i_data_4016 (i_data_4016),
        .i_pressed   (matrix_pressed),
        .o_row       (scan_row),
        .o_column    (scan_column),
        .o_data_4017 (o_data_4017)
    );

    // Pure lookup, so report changes reach $4017 in the same cycle
    hvc_key_matrix u_matrix (
        .i_report  (i_report),
        .i_row     (scan_row),
        .i_column  (scan_column),
        .o_pressed (matrix_pressed)
    );

endmodule

`default_nettype wire

//--- verif/hvc_keyboard_sva.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scan control assertions: $4017 padding bits, row range and reset value
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module hvc_keyboard_sva (
    input logic                     i_clk,
    input logic                     i_reset,
    input hvc_kbd_pkg::hvc_row_t    i_row,
    input logic [7:0]               i_data_4017
);
    timeunit 1ns;
    timeprecision 100ps;

    // Only bits 4 to 1 carry keys
    a_padding_zero : assert property (@(posedge i_clk) disable iff (i_reset)
        (i_data_4017[0] == 1'b0) && (i_data_4017[7:5] == 3'b000))
        else $error("$4017 padding bits set: %h", i_data_4017);

    a_row_range : assert property (@(posedge i_clk) disable iff (i_reset)
        i_row <= 4'd9)
        else $error("Scan row out of range: %0d", i_row);

    // Disabled keyboard reads all keys released
    a_reset_value : assert property (@(posedge i_clk)
        i_reset |=> (i_data_4017 == 8'h1E))
        else $error("$4017 after reset is %h", i_data_4017);

endmodule

bind hvc_scan_ctrl hvc_keyboard_sva u_sva (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_row       (o_row),
    .i_data_4017 (o_data_4017)
);

`default_nettype wire

//--- verif/hvc_keyboard_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HVC keyboard testbench: directed $4016 write and $4017 read scans
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module hvc_keyboard_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import hvc_kbd_pkg::*;

    // Tests take about 600 cycles, so the limit leaves a wide margin
    localparam int TIMEOUT_CYCLES = 4000;

    logic        clk;
    logic        reset;
    logic        wr_4016;
    hvc_cmd_t    cmd;
    usb_report_t usb_report;
    logic [7:0]  data_4017;

    integer seed;
    int     cycles;
    int     checks;
    int     errors;
    int     test_errors;

    hvc_keyboard dut0 (
        .i_clk       (clk),
        .i_reset     (reset),
        .i_wr_4016   (wr_4016),
        .i_data_4016 (cmd),
        .i_report    (usb_report),
        .o_data_4017 (data_4017)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    // Expected $4017 byte from the key map and the modifier byte
    function automatic logic [7:0] expected_byte(usb_report_t rpt, int row, int column);
        logic [3:0]   held;
        usb_keycode_t code;
        held = 4'h0;
        if (row >= HVC_ROWS) begin
            return 8'h1E;
        end
        for (int b = 0; b < 4; b++) begin
            code = HVC_KEYMAP[row][column][b];
            for (int s = 0; s < 6; s++) begin
                if (code != KEY_NONE && rpt.keys[s] == code) begin
                    held[b] = 1'b1;
                end
            end
        end
        // Ctrl and Shift positions follow the modifier byte
        if (row == 7 && column == 0) begin
            held[3] = rpt.modifiers[MOD_LCTRL] | rpt.modifiers[MOD_RCTRL];
        end
        if (row == 7 && column == 1) begin
            held[3] = rpt.modifiers[MOD_LSHIFT];
        end
        if (row == 0 && column == 1) begin
            held[2] = rpt.modifiers[MOD_RSHIFT];
        end
        return {3'b000, ~held, 1'b0};
    endfunction

    task automatic check_data(string name, logic [7:0] actual, logic [7:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s = %h, expected %h",
                     $time, name, actual, expected);
        end
    endtask

    // One strobe cycle, called and returning on a falling edge
    task automatic write_cmd(logic enable, logic column, logic scan_reset);
        cmd.unused     = '0;
        cmd.enable     = enable;
        cmd.column     = column;
        cmd.scan_reset = scan_reset;
        wr_4016        = 1'b1;
        @(negedge clk);
        wr_4016 = 1'b0;
    endtask

    task automatic read_position(int row, int column);
        check_data($sformatf("o_data_4017 r%0d c%0d", row, column), data_4017,
                   expected_byte(usb_report, row, column));
    endtask

    task automatic full_scan(usb_report_t rpt, int rows);
        usb_report = rpt;
        write_cmd(1'b1, 1'b0, 1'b1);
        for (int r = 0; r < rows; r++) begin
            write_cmd(1'b1, 1'b0, 1'b0);
            read_position(r, 0);
            write_cmd(1'b1, 1'b1, 1'b0);
            read_position(r, 1);
        end
    endtask

    task automatic finish_test(string name);
        $display("Test %-16s %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic test_reset_disable();
        usb_report_t rpt;
        rpt         = '0;
        rpt.keys[0] = 8'h41;
        rpt.keys[3] = 8'h1E;
        rpt.modifiers[MOD_LSHIFT] = 1'b1;
        usb_report = rpt;
        @(negedge clk);
        check_data("o_data_4017 after reset", data_4017, 8'h1E);
        write_cmd(1'b1, 1'b0, 1'b1);
        // F8 held at row 0 column 0 bit 0
        check_data("o_data_4017 enabled r0 c0", data_4017, 8'h1C);
        write_cmd(1'b0, 1'b0, 1'b0);
        check_data("o_data_4017 disabled", data_4017, 8'h1E);
        finish_test("reset_disable");
    endtask

    task automatic test_random_keys();
        usb_report_t rpt;
        int          row;
        int          column;
        int          bit_idx;
        int          slot;
        for (int n = 0; n < 21; n++) begin
            do begin
                row     = $unsigned($random(seed)) % HVC_ROWS;
                column  = $unsigned($random(seed)) % 2;
                bit_idx = $unsigned($random(seed)) % 4;
            end while (HVC_KEYMAP[row][column][bit_idx] == KEY_NONE);
            slot = $unsigned($random(seed)) % 6;
            rpt  = '0;
            rpt.keys[slot] = HVC_KEYMAP[row][column][bit_idx];
            // Last pass holds key 2, which sits at two positions
            if (n == 20) begin
                rpt.keys[slot] = 8'h1F;
            end
            full_scan(rpt, HVC_ROWS);
        end
        finish_test("random_keys");
    endtask

    task automatic test_row_keys();
        usb_report_t rpt;
        rpt         = '0;
        rpt.keys[0] = 8'h41;
        rpt.keys[2] = 8'h28;
        rpt.keys[5] = 8'h30;
        // A and P live in other rows
        rpt.keys[1] = 8'h04;
        rpt.keys[4] = 8'h13;
        // Pairs past row 8 must not show the row 0 keys
        full_scan(rpt, HVC_ROWS + 2);
        write_cmd(1'b1, 1'b0, 1'b1);
        check_data("o_data_4017 r0 c0 row keys", data_4017, 8'h08);
        finish_test("row_keys");
    endtask

    task automatic test_modifiers();
        usb_report_t rpt;
        int          mods [4] = '{MOD_LCTRL, MOD_RCTRL, MOD_LSHIFT, MOD_RSHIFT};
        for (int m = 0; m < 4; m++) begin
            rpt = '0;
            rpt.modifiers[mods[m]] = 1'b1;
            full_scan(rpt, HVC_ROWS);
        end
        finish_test("modifiers");
    endtask

    task automatic test_scan_reset();
        usb_report_t rpt;
        rpt         = '0;
        rpt.keys[0] = 8'h41;
        rpt.keys[1] = 8'h18;
        full_scan(rpt, 4);
        // Column bit is ignored while scan_reset is set
        write_cmd(1'b1, 1'b1, 1'b1);
        read_position(0, 0);
        write_cmd(1'b1, 1'b0, 1'b0);
        read_position(0, 0);
        write_cmd(1'b1, 1'b1, 1'b0);
        read_position(0, 1);
        write_cmd(1'b1, 1'b0, 1'b0);
        read_position(1, 0);
        finish_test("scan_reset");
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        wr_4016     = 1'b0;
        cmd         = '0;
        usb_report  = '0;
        seed        = 32'h3bd00066;
        cycles      = 0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset_disable();
        full_scan('0, HVC_ROWS + 2);
        finish_test("empty_scan");
        test_random_keys();
        test_row_keys();
        test_modifiers();
        test_scan_reset();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
src/hvc_kbd_pkg.sv
src/hvc_key_matrix.sv
src/hvc_scan_ctrl.sv
src/hvc_keyboard.sv
verif/hvc_keyboard_sva.sv
verif/hvc_keyboard_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the HVC keyboard testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module hvc_keyboard_tb \
    -f project.f -o hvc_keyboard_sim

./obj_dir/hvc_keyboard_sim | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
